/* design/tlu_params.svh */
////////////////////
// trigger controller register map
// addresses, reset values, version byte
// and output FIFO depth
////////////////////
`ifndef TLU_PARAMS_SVH
`define TLU_PARAMS_SVH

`define TLU_VERSION         8'd6

// address 0 reads the version, a write there is a soft reset
`define TLU_ADDR_RST        16'd0
`define TLU_ADDR_CONF       16'd1
`define TLU_ADDR_CNT0       16'd8   // counter byte 0, latches upper bytes on read
`define TLU_ADDR_CNT1       16'd9
`define TLU_ADDR_CNT2       16'd10
`define TLU_ADDR_CNT3       16'd11  // write loads the counter
`define TLU_ADDR_LOST       16'd12
`define TLU_ADDR_TRIG_SEL   16'd13
`define TLU_ADDR_VETO_SEL   16'd14
`define TLU_ADDR_TRIG_INV   16'd15
`define TLU_ADDR_MAX0       16'd16
`define TLU_ADDR_MAX1       16'd17
`define TLU_ADDR_MAX2       16'd18
`define TLU_ADDR_MAX3       16'd19
`define TLU_NUM_REGS        16'd20

`define TLU_VETO_SEL_RESET  8'hFF   // all vetoes active
`define TLU_FIFO_DEPTH      8

`endif

/* design/tlu_bus_pkg.sv */
////////////////////
// register bus types
// address and data byte of the 8-bit
// configuration bus
////////////////////
package tlu_bus_pkg;

    // 16-bit bus address, only the low range is decoded
    typedef logic [15:0] bus_addr_t;

    typedef logic [7:0] bus_data_t;  // one register byte

endpackage

/* design/tlu_trigger_pkg.sv */
////////////////////
// trigger path types
// input vectors, counters, FIFO word
// and trigger FSM states
////////////////////
package tlu_trigger_pkg;

    typedef logic [7:0] trig_vec_t;      // one bit per trigger or veto input

    // running trigger number and its limit
    typedef logic [31:0] trig_count_t;

    // bit 31 marks a trigger word, 30..0 low counter bits
    typedef logic [31:0] trigger_word_t;

    typedef logic [7:0] lost_count_t;    // saturates at 255

    typedef enum logic [1:0] {
        IDLE,
        ACCEPT,     // flag high, counter stepped
        WAIT_ACK,
        WRITE       // one word into the FIFO
    } trig_state_t;

endpackage

/* design/tlu_reg_decode.sv */
////////////////////
// register bank of the trigger controller
// bus writes and registered readback,
// soft reset on address 0, counter load
// from shadow bytes, latched counter bytes
////////////////////
`include "tlu_params.svh"

module tlu_reg_decode (
    input  logic                        BUS_CLK,
    input  logic                        RST,
    input  tlu_bus_pkg::bus_addr_t      BUS_ADD,
    input  tlu_bus_pkg::bus_data_t      BUS_DATA_IN,
    input  logic                        BUS_RD,
    input  logic                        BUS_WR,
    output tlu_bus_pkg::bus_data_t      BUS_DATA_OUT,
    input  tlu_trigger_pkg::trig_count_t trig_count,
    input  tlu_trigger_pkg::lost_count_t lost_count,
    output tlu_trigger_pkg::trig_vec_t  trig_select,
    output tlu_trigger_pkg::trig_vec_t  trig_invert,
    output tlu_trigger_pkg::trig_vec_t  veto_select,
    output logic                        conf_enable,
    output tlu_trigger_pkg::trig_count_t count_max,
    output logic                        count_load,
    output tlu_trigger_pkg::trig_count_t count_load_value,
    output logic                        soft_rst
);

    logic                           soft_wr_ff;  // write to address 0 seen last cycle
    logic                           addr_valid;
    tlu_bus_pkg::bus_data_t         conf_reg;
    logic [23:0]                    cnt_shadow;  // bytes 2..0 of the next counter load
    tlu_trigger_pkg::trig_count_t   count_buf;

    assign addr_valid = BUS_ADD < `TLU_NUM_REGS;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_wr_ff <= 1'b0;
        else
            soft_wr_ff <= BUS_WR && (BUS_ADD == `TLU_ADDR_RST);
    end

    // shared reset for every block of the controller
    assign soft_rst = RST | soft_wr_ff;

    assign conf_enable = conf_reg[3];  // other conf bits are spare

    always_ff @(posedge BUS_CLK)
    begin
        if (soft_rst)
        begin
            conf_reg    <= '0;
            cnt_shadow  <= '0;
            trig_select <= '0;
            veto_select <= `TLU_VETO_SEL_RESET;
            trig_invert <= '0;
            count_max   <= '0;
        end
        else if (BUS_WR && addr_valid)
        begin
            case (BUS_ADD)
                `TLU_ADDR_CONF:     conf_reg <= BUS_DATA_IN;
                `TLU_ADDR_CNT0:     cnt_shadow[7:0] <= BUS_DATA_IN;
                `TLU_ADDR_CNT1:     cnt_shadow[15:8] <= BUS_DATA_IN;
                `TLU_ADDR_CNT2:     cnt_shadow[23:16] <= BUS_DATA_IN;
                `TLU_ADDR_TRIG_SEL: trig_select <= BUS_DATA_IN;
                `TLU_ADDR_VETO_SEL: veto_select <= BUS_DATA_IN;
                `TLU_ADDR_TRIG_INV: trig_invert <= BUS_DATA_IN;
                `TLU_ADDR_MAX0:     count_max[7:0] <= BUS_DATA_IN;
                `TLU_ADDR_MAX1:     count_max[15:8] <= BUS_DATA_IN;
                `TLU_ADDR_MAX2:     count_max[23:16] <= BUS_DATA_IN;
                `TLU_ADDR_MAX3:     count_max[31:24] <= BUS_DATA_IN;
                default: ;  // read-only and unused addresses
            endcase
        end
    end

    // top byte comes straight from the bus
    always_ff @(posedge BUS_CLK)
    begin
        if (soft_rst)
            count_load <= 1'b0;
        else
            count_load <= BUS_WR && (BUS_ADD == `TLU_ADDR_CNT3);
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_WR && (BUS_ADD == `TLU_ADDR_CNT3))
            count_load_value <= {BUS_DATA_IN, cnt_shadow};
    end

    // reading byte 0 freezes the rest so a 4-byte read is consistent
    always_ff @(posedge BUS_CLK)
    begin
        if (soft_rst)
            count_buf <= '0;
        else if (BUS_RD && (BUS_ADD == `TLU_ADDR_CNT0))
            count_buf <= trig_count;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (soft_rst)
            BUS_DATA_OUT <= '0;
        else if (BUS_RD)
        begin
            case (BUS_ADD)
                `TLU_ADDR_RST:      BUS_DATA_OUT <= `TLU_VERSION;
                `TLU_ADDR_CONF:     BUS_DATA_OUT <= conf_reg;
                `TLU_ADDR_CNT0:     BUS_DATA_OUT <= trig_count[7:0];  // live value
                `TLU_ADDR_CNT1:     BUS_DATA_OUT <= count_buf[15:8];
                `TLU_ADDR_CNT2:     BUS_DATA_OUT <= count_buf[23:16];
                `TLU_ADDR_CNT3:     BUS_DATA_OUT <= count_buf[31:24];
                `TLU_ADDR_LOST:     BUS_DATA_OUT <= lost_count;
                `TLU_ADDR_TRIG_SEL: BUS_DATA_OUT <= trig_select;
                `TLU_ADDR_VETO_SEL: BUS_DATA_OUT <= veto_select;
                `TLU_ADDR_TRIG_INV: BUS_DATA_OUT <= trig_invert;
                `TLU_ADDR_MAX0:     BUS_DATA_OUT <= count_max[7:0];
                `TLU_ADDR_MAX1:     BUS_DATA_OUT <= count_max[15:8];
                `TLU_ADDR_MAX2:     BUS_DATA_OUT <= count_max[23:16];
                `TLU_ADDR_MAX3:     BUS_DATA_OUT <= count_max[31:24];
                default:            BUS_DATA_OUT <= '0;
            endcase
        end
    end

endmodule

/* design/trigger_input_conditioner.sv */
////////////////////
// trigger input conditioning
// invert, mask and OR of triggers and vetoes,
// three-stage synchronizers, rising edge flag
////////////////////
module trigger_input_conditioner (
    input  logic                        BUS_CLK,
    input  logic                        RST,
    input  logic                        soft_rst,
    input  tlu_trigger_pkg::trig_vec_t  TRIGGER,
    input  tlu_trigger_pkg::trig_vec_t  TRIGGER_VETO,
    input  tlu_trigger_pkg::trig_vec_t  trig_select,
    input  tlu_trigger_pkg::trig_vec_t  trig_invert,
    input  tlu_trigger_pkg::trig_vec_t  veto_select,
    output logic                        trig_edge,
    output logic                        veto
);

    logic       clr;
    logic       trig_or;
    logic       veto_or;
    logic [3:0] trig_sync;  // [2:0] synchronizer, [3] previous value
    logic [2:0] veto_sync;

    assign clr = RST | soft_rst;

    // inverted inputs let an active-low source idle quietly
    assign trig_or = |((TRIGGER ^ trig_invert) & trig_select);
    assign veto_or = |(TRIGGER_VETO & veto_select);

    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
        begin
            trig_sync <= '0;
            veto_sync <= '0;
            trig_edge <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[2:0], trig_or};
            veto_sync <= {veto_sync[1:0], veto_or};
            trig_edge <= trig_sync[2] & ~trig_sync[3];  // rising edge, 4 cycles after input
        end
    end

    assign veto = veto_sync[2];

endmodule

/* design/trigger_fsm.sv */
////////////////////
// trigger acceptance FSM
// accepts an edge when enabled, not vetoed and
// below the limit, waits for the acknowledge,
// then writes one trigger word
////////////////////
module trigger_fsm (
    input  logic                            BUS_CLK,
    input  logic                            RST,
    input  logic                            soft_rst,
    input  logic                            trig_edge,
    input  logic                            veto,
    input  logic                            EXT_TRIGGER_ENABLE,
    input  logic                            conf_enable,
    input  logic                            TRIGGER_ACKNOWLEDGE,
    input  tlu_trigger_pkg::trig_count_t    count_max,
    input  logic                            count_load,
    input  tlu_trigger_pkg::trig_count_t    count_load_value,
    output logic                            TRIGGER_ACCEPTED_FLAG,
    output tlu_trigger_pkg::trig_count_t    trig_count,
    output logic                            wr_en,
    output tlu_trigger_pkg::trigger_word_t  wr_data
);

    tlu_trigger_pkg::trig_state_t   state;
    tlu_trigger_pkg::trig_state_t   state_next;
    tlu_trigger_pkg::trig_count_t   count_at_accept;  // value before the increment
    logic                           clr;
    logic                           trig_enabled;
    logic                           limit_reached;
    logic                           accept;

    assign clr = RST | soft_rst;
    assign trig_enabled = EXT_TRIGGER_ENABLE | conf_enable;

    // a zero maximum means no limit
    assign limit_reached = (count_max != '0) && (trig_count >= count_max);

    // edges outside IDLE are simply lost
    assign accept = (state == tlu_trigger_pkg::IDLE) && trig_edge && trig_enabled
                    && !veto && !limit_reached;

    always_comb
    begin
        state_next = state;
        case (state)
            tlu_trigger_pkg::IDLE:
                if (accept)
                    state_next = tlu_trigger_pkg::ACCEPT;
            tlu_trigger_pkg::ACCEPT:
                state_next = tlu_trigger_pkg::WAIT_ACK;
            tlu_trigger_pkg::WAIT_ACK:
                if (TRIGGER_ACKNOWLEDGE)
                    state_next = tlu_trigger_pkg::WRITE;
            tlu_trigger_pkg::WRITE:
                state_next = tlu_trigger_pkg::IDLE;
            default:
                state_next = tlu_trigger_pkg::IDLE;
        endcase
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
            state <= tlu_trigger_pkg::IDLE;
        else
            state <= state_next;
    end

    // bus load wins over a trigger in the same cycle
    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
            trig_count <= '0;
        else if (count_load)
            trig_count <= count_load_value;
        else if (accept)
            trig_count <= trig_count + 1'b1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (accept)
            count_at_accept <= trig_count;
    end

    assign TRIGGER_ACCEPTED_FLAG = (state == tlu_trigger_pkg::ACCEPT);
    assign wr_en = (state == tlu_trigger_pkg::WRITE);
    assign wr_data = {1'b1, count_at_accept[30:0]};  // msb tags a trigger word

endmodule

/* design/trigger_data_fifo.sv */
////////////////////
// output FIFO for trigger words
// first-word-fall-through, drops writes
// when full and counts them, saturating
////////////////////
`include "tlu_params.svh"

module trigger_data_fifo (
    input  logic                            BUS_CLK,
    input  logic                            RST,
    input  logic                            soft_rst,
    input  logic                            wr_en,
    input  tlu_trigger_pkg::trigger_word_t  wr_data,
    input  logic                            FIFO_READ,
    output logic                            FIFO_EMPTY,
    output tlu_trigger_pkg::trigger_word_t  FIFO_DATA,
    output tlu_trigger_pkg::lost_count_t    lost_count
);

    localparam int unsigned ADDR_W = $clog2(`TLU_FIFO_DEPTH);
    localparam int unsigned CNT_W = ADDR_W + 1;

    tlu_trigger_pkg::trigger_word_t mem [`TLU_FIFO_DEPTH];
    logic [ADDR_W-1:0]              wr_ptr;
    logic [ADDR_W-1:0]              rd_ptr;
    logic [CNT_W-1:0]               fill;
    logic                           clr;
    logic                           full;
    logic                           do_write;
    logic                           do_read;

    assign clr = RST | soft_rst;
    assign full = (fill == CNT_W'(`TLU_FIFO_DEPTH));
    assign FIFO_EMPTY = (fill == '0);
    assign do_write = wr_en && !full;
    assign do_read = FIFO_READ && !FIFO_EMPTY;  // pop on empty ignored

    assign FIFO_DATA = mem[rd_ptr];  // head word always on the output

    always_ff @(posedge BUS_CLK)
    begin
        if (do_write)
            mem[wr_ptr] <= wr_data;
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
            lost_count <= '0;
        else if (wr_en && full && (lost_count != '1))
            lost_count <= lost_count + 1'b1;
    end

endmodule

/* design/tlu_controller_core.sv */
////////////////////
// trigger controller top level
// register decode, input conditioner,
// trigger FSM and output FIFO
////////////////////
module tlu_controller_core (
    input  logic                            BUS_CLK,
    input  logic                            RST,
    input  tlu_bus_pkg::bus_addr_t          BUS_ADD,
    input  tlu_bus_pkg::bus_data_t          BUS_DATA_IN,
    input  logic                            BUS_RD,
    input  logic                            BUS_WR,
    output tlu_bus_pkg::bus_data_t          BUS_DATA_OUT,
    input  tlu_trigger_pkg::trig_vec_t      TRIGGER,       // asynchronous levels
    input  tlu_trigger_pkg::trig_vec_t      TRIGGER_VETO,
    input  logic                            EXT_TRIGGER_ENABLE,
    input  logic                            TRIGGER_ACKNOWLEDGE,
    output logic                            TRIGGER_ACCEPTED_FLAG,
    input  logic                            FIFO_READ,
    output logic                            FIFO_EMPTY,
    output tlu_trigger_pkg::trigger_word_t  FIFO_DATA
);

    tlu_trigger_pkg::trig_vec_t     trig_select;
    tlu_trigger_pkg::trig_vec_t     trig_invert;
    tlu_trigger_pkg::trig_vec_t     veto_select;
    tlu_trigger_pkg::trig_count_t   count_max;
    tlu_trigger_pkg::trig_count_t   count_load_value;
    tlu_trigger_pkg::trig_count_t   trig_count;
    tlu_trigger_pkg::trigger_word_t wr_data;
    tlu_trigger_pkg::lost_count_t   lost_count;
    logic                           conf_enable;
    logic                           count_load;
    logic                           soft_rst;
    logic                           trig_edge;
    logic                           veto;
    logic                           wr_en;

    tlu_reg_decode reg_decode_i (
        .BUS_CLK(BUS_CLK), .RST(RST),
        .BUS_ADD(BUS_ADD), .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_RD(BUS_RD), .BUS_WR(BUS_WR), .BUS_DATA_OUT(BUS_DATA_OUT),
        .trig_count(trig_count), .lost_count(lost_count),
        .trig_select(trig_select), .trig_invert(trig_invert),
        .veto_select(veto_select), .conf_enable(conf_enable),
        .count_max(count_max), .count_load(count_load),
        .count_load_value(count_load_value), .soft_rst(soft_rst)
    );

    trigger_input_conditioner input_conditioner_i (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst),
        .TRIGGER(TRIGGER), .TRIGGER_VETO(TRIGGER_VETO),
        .trig_select(trig_select), .trig_invert(trig_invert),
        .veto_select(veto_select),
        .trig_edge(trig_edge), .veto(veto)
    );

    trigger_fsm trigger_fsm_i (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst),
        .trig_edge(trig_edge), .veto(veto),
        .EXT_TRIGGER_ENABLE(EXT_TRIGGER_ENABLE), .conf_enable(conf_enable),
        .TRIGGER_ACKNOWLEDGE(TRIGGER_ACKNOWLEDGE),
        .count_max(count_max), .count_load(count_load),
        .count_load_value(count_load_value),
        .TRIGGER_ACCEPTED_FLAG(TRIGGER_ACCEPTED_FLAG),
        .trig_count(trig_count), .wr_en(wr_en), .wr_data(wr_data)
    );

    trigger_data_fifo data_fifo_i (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst),
        .wr_en(wr_en), .wr_data(wr_data),
        .FIFO_READ(FIFO_READ), .FIFO_EMPTY(FIFO_EMPTY),
        .FIFO_DATA(FIFO_DATA), .lost_count(lost_count)
    );

endmodule

/* tests/tlu_bus_tasks.svh */
////////////////////
// testbench helpers for the trigger controller
// register bus access, trigger and FIFO
// handshakes, typed compare tasks
////////////////////

task automatic bus_write(input tlu_bus_pkg::bus_addr_t addr,
                         input tlu_bus_pkg::bus_data_t data);
    @(posedge BUS_CLK);
    #2;
    BUS_ADD = addr;
    BUS_DATA_IN = data;
    BUS_WR = 1'b1;
    @(posedge BUS_CLK);  // stored at this edge
    #2;
    BUS_WR = 1'b0;
endtask

task automatic bus_read(input tlu_bus_pkg::bus_addr_t addr,
                        output tlu_bus_pkg::bus_data_t data);
    @(posedge BUS_CLK);
    #2;
    BUS_ADD = addr;
    BUS_RD = 1'b1;
    @(posedge BUS_CLK);
    #2;
    BUS_RD = 1'b0;
    data = BUS_DATA_OUT;  // registered one cycle after the read
endtask

task automatic compare_byte(input tlu_bus_pkg::bus_data_t got,
                            input tlu_bus_pkg::bus_data_t exp, input string what);
    if (got !== exp)
    begin
        $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic compare_word(input tlu_trigger_pkg::trigger_word_t got,
                            input tlu_trigger_pkg::trigger_word_t exp, input string what);
    if (got !== exp)
    begin
        $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

// drives the active level until the flag shows up or 100 cycles pass
task automatic fire_trigger(input tlu_trigger_pkg::trig_vec_t active,
                            input tlu_trigger_pkg::trig_vec_t idle, output bit seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    @(posedge BUS_CLK);
    #2;
    TRIGGER = active;
    while (!seen && cycles < 100)
    begin
        @(posedge BUS_CLK);
        #2;
        seen = TRIGGER_ACCEPTED_FLAG;
        cycles++;
    end
    TRIGGER = idle;
endtask

task automatic acknowledge();
    @(posedge BUS_CLK);
    #2;
    TRIGGER_ACKNOWLEDGE = 1'b1;
    @(posedge BUS_CLK);
    #2;
    TRIGGER_ACKNOWLEDGE = 1'b0;
endtask

task automatic accept_trigger(input tlu_trigger_pkg::trig_vec_t active,
                              input tlu_trigger_pkg::trig_vec_t idle);
    bit seen;
    fire_trigger(active, idle, seen);
    if (!seen)
    begin
        $display("timeout at %0t ns: no accepted flag within 100 cycles", $time);
        errors++;
    end
    else
        acknowledge();
endtask

// waits for a word at the FIFO head, checks it and pops it
task automatic check_fifo_word(input tlu_trigger_pkg::trigger_word_t exp);
    int cycles;
    cycles = 0;
    while (FIFO_EMPTY && cycles < 100)
    begin
        @(posedge BUS_CLK);
        #2;
        cycles++;
    end
    if (FIFO_EMPTY)
    begin
        $display("timeout at %0t ns: FIFO stayed empty for 100 cycles", $time);
        errors++;
    end
    else
    begin
        compare_word(FIFO_DATA, exp, "FIFO word");
        FIFO_READ = 1'b1;
        @(posedge BUS_CLK);
        #2;
        FIFO_READ = 1'b0;
    end
endtask

task automatic check_counter(input tlu_trigger_pkg::trig_count_t exp);
    tlu_bus_pkg::bus_data_t rdata;
    bus_read(`TLU_ADDR_CNT0, rdata);  // latches the upper bytes
    compare_byte(rdata, exp[7:0], "counter byte 0");
    bus_read(`TLU_ADDR_CNT1, rdata);
    compare_byte(rdata, exp[15:8], "counter byte 1");
    bus_read(`TLU_ADDR_CNT2, rdata);
    compare_byte(rdata, exp[23:16], "counter byte 2");
    bus_read(`TLU_ADDR_CNT3, rdata);
    compare_byte(rdata, exp[31:24], "counter byte 3");
endtask

/* tests/tb_tlu_controller.sv */
////////////////////
// testbench of the trigger controller
// directed tests of registers, trigger path,
// counter limit and FIFO overflow
////////////////////
`include "tlu_params.svh"

module tb_tlu_controller;

    timeunit 1ns;
    timeprecision 1ps;

    logic                           BUS_CLK;
    logic                           RST;
    tlu_bus_pkg::bus_addr_t         BUS_ADD;
    tlu_bus_pkg::bus_data_t         BUS_DATA_IN;
    logic                           BUS_RD;
    logic                           BUS_WR;
    tlu_bus_pkg::bus_data_t         BUS_DATA_OUT;
    tlu_trigger_pkg::trig_vec_t     TRIGGER;
    tlu_trigger_pkg::trig_vec_t     TRIGGER_VETO;
    logic                           EXT_TRIGGER_ENABLE;
    logic                           TRIGGER_ACKNOWLEDGE;
    logic                           TRIGGER_ACCEPTED_FLAG;
    logic                           FIFO_READ;
    logic                           FIFO_EMPTY;
    tlu_trigger_pkg::trigger_word_t FIFO_DATA;

    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    integer seed = 32'h13d9;

    tlu_controller_core tlu_controller_core_i (.*);

    initial
        BUS_CLK = 1'b0;
    always #10 BUS_CLK = ~BUS_CLK;

    `include "tlu_bus_tasks.svh"

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("%s: pass", name);
        else
        begin
            tests_failed++;
            $display("%s: fail", name);
        end
    endtask

    task automatic soft_reset();
        bus_write(`TLU_ADDR_RST, 8'h00);
    endtask

    // one trigger input, bus enable, no veto
    task automatic enable_input(input tlu_trigger_pkg::trig_vec_t sel);
        bus_write(`TLU_ADDR_TRIG_SEL, sel);
        bus_write(`TLU_ADDR_VETO_SEL, 8'h00);
        bus_write(`TLU_ADDR_CONF, 8'h08);
    endtask

    task automatic test_register_defaults();
        tlu_bus_pkg::bus_addr_t addrs [7];
        tlu_bus_pkg::bus_data_t wdata [7];
        tlu_bus_pkg::bus_data_t rdata;
        int start;
        start = errors;
        addrs = '{`TLU_ADDR_CONF, `TLU_ADDR_TRIG_SEL, `TLU_ADDR_TRIG_INV, `TLU_ADDR_MAX0,
                  `TLU_ADDR_MAX1, `TLU_ADDR_MAX2, `TLU_ADDR_MAX3};
        bus_read(`TLU_ADDR_RST, rdata);
        compare_byte(rdata, 8'd6, "version");
        bus_read(`TLU_ADDR_VETO_SEL, rdata);
        compare_byte(rdata, 8'hFF, "veto mask default");
        bus_read(`TLU_ADDR_MAX0, rdata);
        compare_byte(rdata, 8'h00, "max byte 0 default");
        for (int i = 0; i < 7; i++)
        begin
            wdata[i] = $random(seed);
            bus_write(addrs[i], wdata[i]);
        end
        for (int i = 0; i < 7; i++)
        begin
            bus_read(addrs[i], rdata);
            compare_byte(rdata, wdata[i], "register readback");
        end
        finish_test("test 1 register defaults and readback", start);
    endtask

    task automatic test_basic_trigger();
        int start;
        start = errors;
        soft_reset();
        enable_input(8'h04);
        accept_trigger(8'h04, 8'h00);
        check_fifo_word(32'h8000_0000);
        check_counter(32'd1);
        finish_test("test 2 basic trigger", start);
    endtask

    task automatic test_invert_veto();
        bit seen;
        int start;
        start = errors;
        soft_reset();
        TRIGGER = 8'h01;  // active-low source idles high
        bus_write(`TLU_ADDR_TRIG_INV, 8'h01);
        enable_input(8'h01);
        accept_trigger(8'h00, 8'h01);
        check_fifo_word(32'h8000_0000);
        bus_write(`TLU_ADDR_VETO_SEL, 8'h02);
        TRIGGER_VETO = 8'h02;
        fire_trigger(8'h00, 8'h01, seen);
        if (seen)
        begin
            $display("accepted flag raised at %0t ns while the veto was active", $time);
            errors++;
            acknowledge();
        end
        TRIGGER_VETO = 8'h00;
        finish_test("test 3 invert and veto", start);
    endtask

    task automatic test_counter_limit();
        bit seen;
        int start;
        start = errors;
        soft_reset();
        enable_input(8'h04);
        bus_write(`TLU_ADDR_CNT0, 8'd5);
        bus_write(`TLU_ADDR_CNT1, 8'd0);
        bus_write(`TLU_ADDR_CNT2, 8'd0);
        bus_write(`TLU_ADDR_CNT3, 8'd0);  // loads the counter
        accept_trigger(8'h04, 8'h00);
        check_fifo_word(32'h8000_0005);
        bus_write(`TLU_ADDR_MAX0, 8'd7);
        accept_trigger(8'h04, 8'h00);     // counter goes 6 to 7
        check_fifo_word(32'h8000_0006);
        fire_trigger(8'h04, 8'h00, seen);
        if (seen)
        begin
            $display("accepted flag raised at %0t ns with the limit reached", $time);
            errors++;
            acknowledge();
        end
        check_counter(32'd7);
        // every byte differs, so byte order of load and readback shows
        bus_write(`TLU_ADDR_CNT0, 8'h78);
        bus_write(`TLU_ADDR_CNT1, 8'h56);
        bus_write(`TLU_ADDR_CNT2, 8'h34);
        bus_write(`TLU_ADDR_CNT3, 8'h12);
        check_counter(32'h1234_5678);
        finish_test("test 4 counter load and limit", start);
    endtask

    task automatic test_fifo_overflow();
        tlu_bus_pkg::bus_data_t rdata;
        int start;
        start = errors;
        soft_reset();
        enable_input(8'h04);
        for (int i = 0; i < 10; i++)
            accept_trigger(8'h04, 8'h00);
        bus_read(`TLU_ADDR_LOST, rdata);
        compare_byte(rdata, 8'd2, "lost count");
        for (int i = 0; i < 8; i++)
            check_fifo_word({1'b1, 31'(i)});
        accept_trigger(8'h04, 8'h00);  // leaves one word in the FIFO
        soft_reset();
        bus_read(`TLU_ADDR_LOST, rdata);
        compare_byte(rdata, 8'd0, "lost count after soft reset");
        check_counter(32'd0);
        if (!FIFO_EMPTY)
        begin
            $display("FIFO still holds data at %0t ns after the soft reset", $time);
            errors++;
        end
        finish_test("test 5 FIFO overflow and soft reset", start);
    endtask

    initial
    begin
        $timeformat(-9, 0, "", 0);
        RST = 1'b1;
        BUS_ADD = '0;
        BUS_DATA_IN = '0;
        BUS_RD = 1'b0;
        BUS_WR = 1'b0;
        TRIGGER = '0;
        TRIGGER_VETO = '0;
        EXT_TRIGGER_ENABLE = 1'b0;
        TRIGGER_ACKNOWLEDGE = 1'b0;
        FIFO_READ = 1'b0;
        repeat (5) @(posedge BUS_CLK);
        #2;
        RST = 1'b0;
        test_register_defaults();
        test_basic_trigger();
        test_invert_veto();
        test_counter_limit();
        test_fifo_overflow();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+design
+incdir+tests
design/tlu_bus_pkg.sv
design/tlu_trigger_pkg.sv
design/tlu_reg_decode.sv
design/trigger_input_conditioner.sv
design/trigger_fsm.sv
design/trigger_data_fifo.sv
design/tlu_controller_core.sv
tests/tb_tlu_controller.sv
